/* filelist.f */
src/stream_pkg.sv
src/udp_hdr_pkg.sv
src/header_capture.sv
src/udp_port_filter.sv
src/loopback_responder.sv
src/frame_serializer.sv
src/udp_loopback_top.sv
verification/udp_loopback_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UDP loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module udp_loopback_tb \
  -f filelist.f -Mdir obj_dir -o udp_loopback_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/udp_loopback_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

/* src/frame_serializer.sv */
// Outgoing frame serializer
`timescale 1ns/100ps

module frame_serializer (
  input  logic                  clk,
  input  logic                  rst,
  input  udp_hdr_pkg::hdr_rec_t rsp_hdr,
  input  logic                  rsp_hdr_valid,
  output logic                  rsp_hdr_ready,
  input  stream_pkg::beat_t     flt_pay,
  input  logic                  flt_pay_valid,
  output logic                  flt_pay_ready,
  output stream_pkg::beat_t     out_beat,
  output logic                  out_valid,
  input  logic                  out_ready
);
  import stream_pkg::*;
  import udp_hdr_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_HDR,
    S_PAY
  } state_t;

  state_t     state_q;
  logic [2:0] idx_q;
  hdr_rec_t   hdr_q;
  beat_t      out_q;
  logic       out_valid_q;
  logic       load_ok;
  logic       final_hdr;
  beat_t      hdr_beat;

  // Output register is free or drains this cycle
  assign load_ok   = !out_valid_q || out_ready;
  assign final_hdr = idx_q == 3'(HDR_BEATS - 1);

  assign rsp_hdr_ready = state_q == S_IDLE;
  assign flt_pay_ready = state_q == S_PAY && load_ok;

  assign out_beat  = out_q;
  assign out_valid = out_valid_q;

  always_comb begin
    for (int i = 0; i < KEEP_W; i++) begin
      hdr_beat.data[8*i +: 8] = hdr_q.win.bytes[{idx_q, 3'd0} + i];
    end
    hdr_beat.keep = '1;
    hdr_beat.last = 1'b0;
    hdr_beat.user = 1'b0;
    if (final_hdr && hdr_q.ends_in_window) begin
      hdr_beat.keep = hdr_q.last_keep;
      hdr_beat.last = 1'b1;
      hdr_beat.user = hdr_q.last_user;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      idx_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (out_ready) begin
        out_valid_q <= 1'b0;
      end
      case (state_q)
        S_IDLE: begin
          if (rsp_hdr_valid) begin
            state_q <= S_HDR;
            idx_q   <= '0;
          end
        end
        S_HDR: begin
          if (load_ok) begin
            out_valid_q <= 1'b1;
            idx_q       <= idx_q + 3'd1;
            if (final_hdr) begin
              state_q <= hdr_q.ends_in_window ? S_IDLE : S_PAY;
            end
          end
        end
        default: begin
          if (flt_pay_valid && flt_pay_ready) begin
            out_valid_q <= 1'b1;
            if (flt_pay.last) begin
              state_q <= S_IDLE;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_hdr_valid && rsp_hdr_ready) begin
      hdr_q <= rsp_hdr;
    end
    if (state_q == S_HDR && load_ok) begin
      out_q <= hdr_beat;
    end else if (flt_pay_valid && flt_pay_ready) begin
      out_q <= flt_pay;
    end
  end

endmodule

/* src/header_capture.sv */
// Header window capture
`timescale 1ns/100ps

module header_capture (
  input  logic                 clk,
  input  logic                 rst,
  input  stream_pkg::beat_t    in_beat,
  input  logic                 in_valid,
  output logic                 in_ready,
  output udp_hdr_pkg::hdr_rec_t cap_hdr,
  output logic                 cap_hdr_valid,
  input  logic                 cap_hdr_ready,
  output stream_pkg::beat_t    cap_pay,
  output logic                 cap_pay_valid,
  input  logic                 cap_pay_ready
);
  import stream_pkg::*;
  import udp_hdr_pkg::*;

  logic [2:0] cnt_q;
  logic       hdr_valid_q;
  logic       fwd_q;
  hdr_rec_t   hdr_q;
  logic       in_xfer;
  logic       win_beat;
  logic       win_done;

  // Stall input while a finished header waits downstream
  assign in_ready = !hdr_valid_q && (!fwd_q || cap_pay_ready);
  assign in_xfer  = in_valid && in_ready;
  assign win_beat = in_xfer && !fwd_q;
  assign win_done = win_beat && (in_beat.last || cnt_q == 3'(HDR_BEATS - 1));

  assign cap_hdr       = hdr_q;
  assign cap_hdr_valid = hdr_valid_q;

  // Beats past the window go straight through
  assign cap_pay       = in_beat;
  assign cap_pay_valid = in_valid && fwd_q && !hdr_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q       <= '0;
      hdr_valid_q <= 1'b0;
      fwd_q       <= 1'b0;
    end else begin
      if (hdr_valid_q && cap_hdr_ready) begin
        hdr_valid_q <= 1'b0;
      end
      if (win_beat) begin
        cnt_q <= cnt_q + 3'd1;
      end
      if (win_done) begin
        cnt_q       <= '0;
        hdr_valid_q <= 1'b1;
        fwd_q       <= !in_beat.last;
      end
      if (in_xfer && fwd_q && in_beat.last) begin
        fwd_q <= 1'b0;
      end
    end
  end

  // Window bytes land at their frame offsets
  always_ff @(posedge clk) begin
    if (win_beat) begin
      for (int i = 0; i < KEEP_W; i++) begin
        hdr_q.win.bytes[{cnt_q, 3'd0} + i] <= in_beat.data[8*i +: 8];
      end
      hdr_q.last_keep      <= in_beat.keep;
      hdr_q.last_user      <= in_beat.user;
      hdr_q.ends_in_window <= in_beat.last && cnt_q == 3'(HDR_BEATS - 1);
      hdr_q.runt           <= in_beat.last && cnt_q != 3'(HDR_BEATS - 1);
    end
  end

endmodule

/* src/loopback_responder.sv */
// Address and port swap
`timescale 1ns/100ps

module loopback_responder (
  input  logic                  clk,
  input  logic                  rst,
  input  udp_hdr_pkg::hdr_rec_t flt_hdr,
  input  logic                  flt_hdr_valid,
  output logic                  flt_hdr_ready,
  output udp_hdr_pkg::hdr_rec_t rsp_hdr,
  output logic                  rsp_hdr_valid,
  input  logic                  rsp_hdr_ready,
  output logic [7:0]            led
);
  import stream_pkg::*;
  import udp_hdr_pkg::*;

  // Keep lane of the first payload byte in the last window beat
  localparam int LED_LANE = PAYLOAD_OFFSET % KEEP_W;

  hdr_rec_t    hdr_q;
  logic        hdr_valid_q;
  logic [7:0]  led_q;
  hdr_fields_t in_f;
  hdr_rec_t    swapped;
  logic        hdr_take;

  assign in_f = flt_hdr.win.fields;

  // Checksums stay valid since only field order changes
  always_comb begin
    swapped                        = flt_hdr;
    swapped.win.fields.eth.dst_mac = in_f.eth.src_mac;
    swapped.win.fields.eth.src_mac = in_f.eth.dst_mac;
    swapped.win.fields.ip.src_ip   = in_f.ip.dst_ip;
    swapped.win.fields.ip.dst_ip   = in_f.ip.src_ip;
    swapped.win.fields.udp.src_port = in_f.udp.dst_port;
    swapped.win.fields.udp.dst_port = in_f.udp.src_port;
  end

  assign flt_hdr_ready = !hdr_valid_q || rsp_hdr_ready;
  assign hdr_take      = flt_hdr_valid && flt_hdr_ready;

  assign rsp_hdr       = hdr_q;
  assign rsp_hdr_valid = hdr_valid_q;
  assign led           = led_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_valid_q <= 1'b0;
      led_q       <= '0;
    end else begin
      if (hdr_take) begin
        hdr_valid_q <= 1'b1;
      end else if (rsp_hdr_ready) begin
        hdr_valid_q <= 1'b0;
      end
      if (hdr_take && (!flt_hdr.ends_in_window || flt_hdr.last_keep[LED_LANE])) begin
        led_q <= flt_hdr.win.bytes[PAYLOAD_OFFSET];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_take) begin
      hdr_q <= swapped;
    end
  end

endmodule

/* src/stream_pkg.sv */
// Stream beat types
package stream_pkg;

  // Bus width of one beat
  localparam int DATA_W = 64;
  localparam int KEEP_W = DATA_W / 8;

  // Byte lane i carries frame byte i of the beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
    logic              user;
  } beat_t;

endpackage

/* src/udp_hdr_pkg.sv */
// Ethernet, IPv4 and UDP header types
package udp_hdr_pkg;

  localparam int HDR_BEATS      = 6;
  localparam int HDR_BYTES      = 48;
  // First UDP payload byte in the frame
  localparam int PAYLOAD_OFFSET = 42;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  typedef struct packed {
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] ident;
    logic [15:0] flags_frag;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] hdr_csum;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  typedef struct packed {
    eth_hdr_t                                      eth;
    ipv4_hdr_t                                     ip;
    udp_hdr_t                                      udp;
    logic [0:HDR_BYTES-PAYLOAD_OFFSET-1][7:0] head_pay;
  } hdr_fields_t;

  // Frame byte 0 sits in the top byte of both views
  typedef union packed {
    logic [0:HDR_BYTES-1][7:0] bytes;
    hdr_fields_t               fields;
  } hdr_window_u;

  typedef struct packed {
    hdr_window_u                     win;
    logic                            ends_in_window;
    logic                            runt;
    logic [stream_pkg::KEEP_W-1:0] last_keep;
    logic                            last_user;
  } hdr_rec_t;

endpackage

/* src/udp_loopback_top.sv */
// UDP loopback core
`timescale 1ns/100ps

module udp_loopback_top #(
  parameter logic [15:0] LOOPBACK_PORT = 16'd1234
) (
  input  logic              clk,
  input  logic              rst,
  input  stream_pkg::beat_t in_beat,
  input  logic              in_valid,
  output logic              in_ready,
  output stream_pkg::beat_t out_beat,
  output logic              out_valid,
  input  logic              out_ready,
  output logic [7:0]        led
);
  import stream_pkg::*;
  import udp_hdr_pkg::*;

  hdr_rec_t cap_hdr;
  logic     cap_hdr_valid;
  logic     cap_hdr_ready;
  beat_t    cap_pay;
  logic     cap_pay_valid;
  logic     cap_pay_ready;
  hdr_rec_t flt_hdr;
  logic     flt_hdr_valid;
  logic     flt_hdr_ready;
  beat_t    flt_pay;
  logic     flt_pay_valid;
  logic     flt_pay_ready;
  hdr_rec_t rsp_hdr;
  logic     rsp_hdr_valid;
  logic     rsp_hdr_ready;

  header_capture cap0 (
    .clk           (clk),
    .rst           (rst),
    .in_beat       (in_beat),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .cap_hdr       (cap_hdr),
    .cap_hdr_valid (cap_hdr_valid),
    .cap_hdr_ready (cap_hdr_ready),
    .cap_pay       (cap_pay),
    .cap_pay_valid (cap_pay_valid),
    .cap_pay_ready (cap_pay_ready)
  );

  udp_port_filter #(
    .LOOPBACK_PORT (LOOPBACK_PORT)
  ) flt0 (
    .clk           (clk),
    .rst           (rst),
    .cap_hdr       (cap_hdr),
    .cap_hdr_valid (cap_hdr_valid),
    .cap_hdr_ready (cap_hdr_ready),
    .cap_pay       (cap_pay),
    .cap_pay_valid (cap_pay_valid),
    .cap_pay_ready (cap_pay_ready),
    .flt_hdr       (flt_hdr),
    .flt_hdr_valid (flt_hdr_valid),
    .flt_hdr_ready (flt_hdr_ready),
    .flt_pay       (flt_pay),
    .flt_pay_valid (flt_pay_valid),
    .flt_pay_ready (flt_pay_ready)
  );

  // Payload bypasses the responder
  loopback_responder rsp0 (
    .clk           (clk),
    .rst           (rst),
    .flt_hdr       (flt_hdr),
    .flt_hdr_valid (flt_hdr_valid),
    .flt_hdr_ready (flt_hdr_ready),
    .rsp_hdr       (rsp_hdr),
    .rsp_hdr_valid (rsp_hdr_valid),
    .rsp_hdr_ready (rsp_hdr_ready),
    .led           (led)
  );

  frame_serializer ser0 (
    .clk           (clk),
    .rst           (rst),
    .rsp_hdr       (rsp_hdr),
    .rsp_hdr_valid (rsp_hdr_valid),
    .rsp_hdr_ready (rsp_hdr_ready),
    .flt_pay       (flt_pay),
    .flt_pay_valid (flt_pay_valid),
    .flt_pay_ready (flt_pay_ready),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

endmodule

/* src/udp_port_filter.sv */
// Loopback frame filter
`timescale 1ns/100ps

module udp_port_filter #(
  parameter logic [15:0] LOOPBACK_PORT = 16'd1234
) (
  input  logic                  clk,
  input  logic                  rst,
  input  udp_hdr_pkg::hdr_rec_t cap_hdr,
  input  logic                  cap_hdr_valid,
  output logic                  cap_hdr_ready,
  input  stream_pkg::beat_t     cap_pay,
  input  logic                  cap_pay_valid,
  output logic                  cap_pay_ready,
  output udp_hdr_pkg::hdr_rec_t flt_hdr,
  output logic                  flt_hdr_valid,
  input  logic                  flt_hdr_ready,
  output stream_pkg::beat_t     flt_pay,
  output logic                  flt_pay_valid,
  input  logic                  flt_pay_ready
);
  import udp_hdr_pkg::*;

  hdr_rec_t    hdr_q;
  logic        hdr_valid_q;
  logic        pay_active_q;
  logic        accept_q;
  hdr_fields_t f;
  logic        accept;
  logic        hdr_take;

  assign f = cap_hdr.win.fields;

  // Plain IPv4 without options, UDP to our port
  assign accept = !cap_hdr.runt &&
                  f.eth.ethertype == ETHERTYPE_IPV4 &&
                  f.ip.version == 4'd4 &&
                  f.ip.ihl == 4'd5 &&
                  f.ip.protocol == IP_PROTO_UDP &&
                  f.udp.dst_port == LOOPBACK_PORT;

  assign cap_hdr_ready = !hdr_valid_q && !pay_active_q;
  assign hdr_take      = cap_hdr_valid && cap_hdr_ready;

  assign flt_hdr       = hdr_q;
  assign flt_hdr_valid = hdr_valid_q;

  // Dropped payload is sunk one beat per cycle
  assign flt_pay       = cap_pay;
  assign flt_pay_valid = cap_pay_valid && pay_active_q && accept_q;
  assign cap_pay_ready = pay_active_q && (!accept_q || flt_pay_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_valid_q  <= 1'b0;
      pay_active_q <= 1'b0;
      accept_q     <= 1'b0;
    end else begin
      if (hdr_valid_q && flt_hdr_ready) begin
        hdr_valid_q <= 1'b0;
      end
      if (hdr_take) begin
        hdr_valid_q  <= accept;
        accept_q     <= accept;
        pay_active_q <= !(cap_hdr.ends_in_window || cap_hdr.runt);
      end
      if (cap_pay_valid && cap_pay_ready && cap_pay.last) begin
        pay_active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_take) begin
      hdr_q <= cap_hdr;
    end
  end

endmodule

/* verification/udp_loopback_tb.sv */
// UDP loopback testbench
`timescale 1ns/100ps

module udp_loopback_tb;
  import stream_pkg::*;

  localparam logic [15:0] PORT      = 16'd1234;
  localparam logic [31:0] SEED      = 32'h0bdd_af1f;
  localparam int          FIRST_PAY = 42;
  localparam int          LIMIT     = 4000;

  logic        clk = 1'b0;
  logic        rst;
  beat_t       in_beat;
  logic        in_valid;
  logic        in_ready;
  beat_t       out_beat;
  logic        out_valid;
  logic        out_ready;
  logic [7:0]  led;

  logic [7:0]  frm[$];
  beat_t       exp_q[$];
  logic [7:0]  exp_led;
  logic [31:0] stim_rng;
  logic [31:0] ready_rng;
  logic        ready_random;
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;

  udp_loopback_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .led       (led)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  // Output byte k of a looped frame comes from this input byte
  function automatic int swap_index(input int k);
    if (k < 12) begin
      return k < 6 ? k + 6 : k - 6;
    end else if (k >= 26 && k < 34) begin
      return k < 30 ? k + 4 : k - 4;
    end else if (k >= 34 && k < 38) begin
      return k < 36 ? k + 2 : k - 2;
    end
    return k;
  endfunction

  function automatic beat_t beat_at(input int k, input logic swap, input logic user);
    beat_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      if (k + i < frm.size()) begin
        b.data[8*i +: 8] = swap ? frm[swap_index(k + i)] : frm[k + i];
        b.keep[i]        = 1'b1;
      end
    end
    b.last = k + 8 >= frm.size();
    b.user = b.last && user;
    return b;
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("** Error @ %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_run();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic time_out(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    errors++;
    finish_run();
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %0d, %s: ok", tests, name);
    end else begin
      $display("test %0d, %s: %0d errors", tests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // Random bytes, then the fields the filter looks at
  task automatic build_frame(input int len, input logic [15:0] dport, input logic [15:0] etype,
                             input logic [7:0] ver_ihl, input logic [7:0] proto);
    logic [31:0] r;
    frm.delete();
    for (int i = 0; i < len; i++) begin
      r = next_rand();
      frm.push_back(r[7:0]);
    end
    frm[12] = etype[15:8];
    frm[13] = etype[7:0];
    frm[14] = ver_ihl;
    frm[23] = proto;
    frm[36] = dport[15:8];
    frm[37] = dport[7:0];
  endtask

  // Reference model, then the input beats
  task automatic exchange_frame(input logic user);
    int n;
    int cnt;
    n = frm.size();
    if (n > 40 && {frm[12], frm[13]} == 16'h0800 && frm[14] == 8'h45 &&
        frm[23] == 8'd17 && {frm[36], frm[37]} == PORT) begin
      for (int k = 0; k < n; k += 8) begin
        exp_q.push_back(beat_at(k, 1'b1, user));
      end
      if (n > FIRST_PAY) begin
        exp_led = frm[FIRST_PAY];
      end
    end
    for (int k = 0; k < n; k += 8) begin
      in_beat  = beat_at(k, 1'b0, user);
      in_valid = 1'b1;
      cnt      = 0;
      #1;
      while (!in_ready && cnt < LIMIT) begin
        @(negedge clk);
        #1;
        cnt++;
      end
      if (!in_ready) begin
        time_out("input beat was never accepted");
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      time_out("expected output beats did not all arrive");
    end
  endtask

  task automatic check_led();
    checks++;
    assert (led == exp_led)
      else flag_mismatch($sformatf("led %h, expected %h", led, exp_led));
  endtask

  task automatic compare_beat();
    beat_t       exp;
    logic [63:0] mask;
    if (exp_q.size() == 0) begin
      $display("unexpected output beat at %0t ns, no looped frame was due", $time);
      errors++;
    end else begin
      exp = exp_q.pop_front();
      for (int i = 0; i < 8; i++) begin
        mask[8*i +: 8] = {8{exp.keep[i]}};
      end
      checks++;
      assert (((out_beat.data ^ exp.data) & mask) == '0 && out_beat.keep == exp.keep &&
              out_beat.last == exp.last && out_beat.user == exp.user)
        else flag_mismatch($sformatf("out %h/%h/%b/%b, expected %h/%h/%b/%b",
                                     out_beat.data, out_beat.keep, out_beat.last,
                                     out_beat.user, exp.data, exp.keep, exp.last, exp.user));
    end
  endtask

  always @(negedge clk) begin
    if (ready_random) begin
      ready_rng = xorshift32(ready_rng);
      out_ready = ready_rng[1:0] != 2'b00;
    end else begin
      out_ready = 1'b1;
    end
  end

  // Beats compared mid-cycle ahead of the posedge transfer
  always @(negedge clk) begin
    #1;
    if (!rst && out_valid && out_ready) begin
      compare_beat();
    end
  end

  hold_check: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && out_beat == $past(out_beat)))
    else flag_mismatch("output beat changed while out_ready was low");

  reset_check: assert property (@(posedge clk)
    $fell(rst) |-> (!out_valid && in_ready && led == 8'd0))
    else flag_mismatch("outputs not idle when reset was released");

  initial begin
    for (int c = 0; c < 200000; c++) begin
      @(posedge clk);
    end
    $display("run did not finish within the cycle limit");
    errors++;
    finish_run();
  end

  initial begin : stimulus
    logic [31:0] r;
    int          len;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_beat      = '0;
    out_ready    = 1'b1;
    ready_random = 1'b0;
    stim_rng     = SEED;
    ready_rng    = SEED;
    exp_led      = 8'd0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    err_mark     = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    #1;
    checks++;
    assert (!out_valid && led == 8'd0 && in_ready)
      else flag_mismatch("outputs not idle after reset");
    end_test("reset state");
    @(negedge clk);

    build_frame(90, PORT, 16'h0800, 8'h45, 8'd17);
    exchange_frame(1'b0);
    build_frame(64, PORT, 16'h0800, 8'h45, 8'd17);
    exchange_frame(1'b1);
    wait_drain();
    check_led();
    end_test("matching frames swapped");

    build_frame(100, PORT + 16'd1, 16'h0800, 8'h45, 8'd17);
    exchange_frame(1'b0);
    build_frame(100, PORT, 16'h86dd, 8'h45, 8'd17);
    exchange_frame(1'b0);
    build_frame(100, PORT, 16'h0800, 8'h45, 8'd6);
    exchange_frame(1'b0);
    build_frame(100, PORT, 16'h0800, 8'h46, 8'd17);
    exchange_frame(1'b0);
    // Five beats with otherwise matching fields
    build_frame(40, PORT, 16'h0800, 8'h45, 8'd17);
    exchange_frame(1'b0);
    build_frame(72, PORT, 16'h0800, 8'h45, 8'd17);
    exchange_frame(1'b0);
    wait_drain();
    check_led();
    end_test("dropped frames");

    build_frame(56, PORT, 16'h0800, 8'h45, 8'd17);
    exchange_frame(1'b0);
    wait_drain();
    check_led();
    build_frame(80, PORT + 16'd1, 16'h0800, 8'h45, 8'd17);
    frm[FIRST_PAY] = ~exp_led;
    exchange_frame(1'b0);
    // Looped but without a payload byte
    build_frame(42, PORT, 16'h0800, 8'h45, 8'd17);
    exchange_frame(1'b0);
    wait_drain();
    check_led();
    end_test("led tracking");

    ready_random = 1'b1;
    for (int f = 0; f < 30; f++) begin
      r = next_rand();
      if (f == 0) begin
        len = 48;
      end else if (f == 1) begin
        len = 44;
      end else if (f == 2) begin
        len = 240;
      end else begin
        len = 42 + int'(r[7:0]) % 160;
      end
      build_frame(len, (r[31:29] == 3'd0 && f > 2 && f != 29) ? PORT + 16'd1 : PORT,
                  16'h0800, 8'h45, 8'd17);
      exchange_frame(r[20]);
    end
    wait_drain();
    ready_random = 1'b0;
    check_led();
    end_test("random back-to-back frames");

    finish_run();
  end

endmodule
